/* hdl/params_pkg.sv */
//**********************************************************
// panel geometry and colour depth are fixed here, sized small
// for simulation; width and half height must be powers of two
//**********************************************************

package params;

    // columns per row, shifted out once per bit-plane
    localparam int unsigned PIXEL_WIDTH = 8;

    // rows per half panel, top and bottom halves scan together
    localparam int unsigned PIXEL_HALFHEIGHT = 4;

    // bits per colour channel, one bit-plane each
    localparam int unsigned BRIGHTNESS_LEVELS = 3;

    // default timing, overridable from the top level
    localparam int unsigned BRIGHTNESS_BASE_TIMEOUT = 4;
    localparam int unsigned BRIGHTNESS_STATE_TIMEOUT_OVERLAP = 10;
    localparam int unsigned FB_CREDITS = 4;

endpackage

/* hdl/types_pkg.sv */
//**********************************************************
// typedefs derived from the panel constants in params
//**********************************************************

package types;

    // column index, counts down during a row load
    typedef logic [$clog2(params::PIXEL_WIDTH)-1:0] col_addr_t;

    // row index within one half of the panel
    typedef logic [$clog2(params::PIXEL_HALFHEIGHT)-1:0] row_addr_t;

    // one-hot bit-plane select, msb is the brightest plane
    typedef logic [params::BRIGHTNESS_LEVELS-1:0] brightness_level_t;

    // binary-coded channels, one bit per plane
    typedef struct packed {
        logic [params::BRIGHTNESS_LEVELS-1:0] red;
        logic [params::BRIGHTNESS_LEVELS-1:0] green;
        logic [params::BRIGHTNESS_LEVELS-1:0] blue;
    } pixel_t;

    // half = 0 selects the top half, 1 the bottom half
    typedef struct packed {
        logic      half;
        row_addr_t row;
        col_addr_t col;
    } fb_addr_t;

endpackage

/* hdl/timeout.sv */
//**********************************************************
// one-shot down-counter, a start while running reloads it
//**********************************************************

module timeout #(
    parameter int unsigned COUNTER_WIDTH = 4
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // counter is valid in the cycle after start
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (running) begin
            // stops at zero and stays there
            counter <= counter - 1'b1;
        end
    end

    // high for exactly value cycles after a start
    assign running = (counter != '0);

endmodule

/* hdl/brightness_timeout.sv */
//**********************************************************
// output enable length is BASE << plane index cycles, the
// overlap flag is only meaningful while output enable is high
//**********************************************************

module brightness_timeout #(
    parameter int unsigned BRIGHTNESS_BASE_TIMEOUT = params::BRIGHTNESS_BASE_TIMEOUT,
    parameter int unsigned BRIGHTNESS_STATE_TIMEOUT_OVERLAP =
        params::BRIGHTNESS_STATE_TIMEOUT_OVERLAP
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     row_latch,
    input  types::brightness_level_t brightness_mask_active,
    output logic                     output_enable,
    output logic                     exceeded_overlap_time
);

    // longest pulse belongs to the msb plane
    localparam int unsigned MAX_WEIGHT =
        BRIGHTNESS_BASE_TIMEOUT << (params::BRIGHTNESS_LEVELS - 1);
    localparam int unsigned COUNT_W = $clog2(MAX_WEIGHT + 1);

    logic               pending;
    logic [COUNT_W-1:0] counter;
    logic [COUNT_W-1:0] weight;
    logic [COUNT_W-1:0] remaining;

    // weight from the one-hot plane, an empty mask counts as lsb
    always_comb begin
        weight = COUNT_W'(BRIGHTNESS_BASE_TIMEOUT);
        for (int i = 0; i < params::BRIGHTNESS_LEVELS; i++) begin
            if (brightness_mask_active[i]) begin
                weight = COUNT_W'(BRIGHTNESS_BASE_TIMEOUT << i);
            end
        end
    end

    // the active mask is captured on the same edge as the latch,
    // so the weight is loaded one cycle later from the pending slot
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pending <= 1'b0;
            counter <= '0;
        end else if (row_latch) begin
            // a new latch always restarts the pulse
            pending <= 1'b1;
            counter <= '0;
        end else if (pending) begin
            pending <= 1'b0;
            counter <= weight - 1'b1;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // pending cycle is the first enable cycle
    assign output_enable = pending || (counter != '0);

    // enable cycles still to go, this one included
    assign remaining = pending ? weight : counter;

    assign exceeded_overlap_time = output_enable &&
        (int'(remaining) <= BRIGHTNESS_STATE_TIMEOUT_OVERLAP);

endmodule

/* hdl/matrix_scan.sv */
//**********************************************************
// overlap must stay below PIXEL_WIDTH + 4 cycles, otherwise the
// next latch lands inside the enable pulse and extends it
//**********************************************************

module matrix_scan #(
    parameter int unsigned BRIGHTNESS_BASE_TIMEOUT = params::BRIGHTNESS_BASE_TIMEOUT,
    parameter int unsigned BRIGHTNESS_STATE_TIMEOUT_OVERLAP =
        params::BRIGHTNESS_STATE_TIMEOUT_OVERLAP
) (
    input  logic                     clk_in,
    input  logic                     reset,
    output types::col_addr_t         column_address,
    output types::row_addr_t         row_address,
    output types::row_addr_t         row_address_active,
    output logic                     load_en,
    output logic                     row_latch,
    output logic                     output_enable,
    output types::brightness_level_t brightness_mask
);

    localparam int unsigned COL_W = $bits(types::col_addr_t);
    // one extra bit so the load counter can hold PIXEL_WIDTH
    localparam int unsigned LOAD_W = $clog2(params::PIXEL_WIDTH + 1);
    localparam types::brightness_level_t MASK_MSB =
        types::brightness_level_t'(1) << (params::BRIGHTNESS_LEVELS - 1);
    localparam types::row_addr_t ROW_LAST =
        types::row_addr_t'(params::PIXEL_HALFHEIGHT - 1);

    logic [1:0]               state;
    logic [2:0]               latch_sr;
    logic                     busy;
    logic                     state_advance;
    logic                     load_start;
    logic                     exceeded_overlap_time;
    types::brightness_level_t brightness_mask_active;

    // a load, or its trailing latch, is still in progress
    assign busy = load_en || (latch_sr != '0);

    // advance when the panel is dark or nearly done with this plane
    assign state_advance = !busy && (!output_enable || exceeded_overlap_time);

    // state[0] is the newest sample, a 0 -> 1 step starts one load
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
        end else begin
            state <= {state[0], state_advance};
        end
    end

    assign load_start = (state == 2'b01);

    // load_en high for PIXEL_WIDTH cycles
    timeout #(
        .COUNTER_WIDTH(LOAD_W)
    ) load_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (load_start),
        .value  (LOAD_W'(params::PIXEL_WIDTH)),
        .counter(),
        .running(load_en)
    );

    // column address width-1 down to 0, in step with load_en
    timeout #(
        .COUNTER_WIDTH(COL_W)
    ) column_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (load_start),
        .value  (COL_W'(params::PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // latch_sr[2] is load_en three cycles ago
    always_ff @(posedge clk_in) begin
        if (reset) begin
            latch_sr <= '0;
        end else begin
            latch_sr <= {latch_sr[1:0], load_en};
        end
    end

    // last column reaches the pins 2 cycles after its address,
    // latch one cycle after that
    assign row_latch = latch_sr[2] && !latch_sr[1];

    // plane and row bookkeeping on each latch
    always_ff @(posedge clk_in) begin
        if (reset) begin
            brightness_mask        <= MASK_MSB;
            brightness_mask_active <= '0;
            row_address            <= '0;
            row_address_active     <= '0;
        end else if (row_latch) begin
            // what was just shifted in is now what the panel shows
            brightness_mask_active <= brightness_mask;
            row_address_active     <= row_address;
            if (brightness_mask[0]) begin
                // lsb done, back to msb on the next row
                brightness_mask <= MASK_MSB;
                row_address     <= (row_address == ROW_LAST) ? '0 : row_address + 1'b1;
            end else begin
                brightness_mask <= brightness_mask >> 1;
            end
        end
    end

    brightness_timeout #(
        .BRIGHTNESS_BASE_TIMEOUT         (BRIGHTNESS_BASE_TIMEOUT),
        .BRIGHTNESS_STATE_TIMEOUT_OVERLAP(BRIGHTNESS_STATE_TIMEOUT_OVERLAP)
    ) oe_timer (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

endmodule

/* hdl/frame_buffer.sv */
//**********************************************************
// the host may hold at most FB_CREDITS writes in flight, there
// is no ready; writes drain only while load_en is low
//**********************************************************

module frame_buffer #(
    parameter int unsigned FB_CREDITS = params::FB_CREDITS
) (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             wr_valid,
    input  types::fb_addr_t  wr_addr,
    input  types::pixel_t    wr_data,
    output logic             credit_return,
    input  logic             load_en,
    input  types::col_addr_t column_address,
    input  types::row_addr_t row_address,
    output types::pixel_t    pixel_top,
    output types::pixel_t    pixel_bottom
);

    localparam int unsigned HALF_DEPTH = params::PIXEL_HALFHEIGHT * params::PIXEL_WIDTH;
    localparam int unsigned IDX_W = $bits(types::row_addr_t) + $bits(types::col_addr_t);
    localparam int unsigned PTR_W = (FB_CREDITS > 1) ? $clog2(FB_CREDITS) : 1;
    localparam int unsigned CNT_W = $clog2(FB_CREDITS + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FB_CREDITS - 1);

    // one array per half so both halves read in the same cycle
    types::pixel_t   mem_top    [HALF_DEPTH];
    types::pixel_t   mem_bottom [HALF_DEPTH];

    // write queue storage
    types::fb_addr_t q_addr [FB_CREDITS];
    types::pixel_t   q_data [FB_CREDITS];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    logic             pop;
    types::fb_addr_t  head_addr;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] rd_idx;

    // commit only while the scan leaves the memory alone
    assign pop = (fifo_count != '0) && !load_en;

    assign head_addr = q_addr[rd_ptr];
    assign head_idx  = {head_addr.row, head_addr.col};
    assign rd_idx    = {row_address, column_address};

    // queue pointers and fill level
    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_count    <= '0;
            credit_return <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            fifo_count <= fifo_count + CNT_W'(wr_valid) - CNT_W'(pop);
            // one credit back per committed write
            credit_return <= pop;
        end
    end

    // queue payload
    always_ff @(posedge clk_in) begin
        if (wr_valid) begin
            q_addr[wr_ptr] <= wr_addr;
            q_data[wr_ptr] <= wr_data;
        end
    end

    // commit the head entry into the selected half
    always_ff @(posedge clk_in) begin
        if (pop) begin
            if (head_addr.half) begin
                mem_bottom[head_idx] <= q_data[rd_ptr];
            end else begin
                mem_top[head_idx] <= q_data[rd_ptr];
            end
        end
    end

    // scan read, data one cycle after the address
    always_ff @(posedge clk_in) begin
        pixel_top    <= mem_top[rd_idx];
        pixel_bottom <= mem_bottom[rd_idx];
    end

endmodule

/* hdl/pixel_shifter.sv */
//**********************************************************
// pixels arrive one cycle after their address, outputs and
// pixel_clk leave one cycle after that
//**********************************************************

module pixel_shifter (
    input  logic                     clk_in,
    input  logic                     reset,
    input  types::pixel_t            pixel_top,
    input  types::pixel_t            pixel_bottom,
    input  types::brightness_level_t brightness_mask,
    input  logic                     load_en,
    output logic [2:0]               rgb_top,
    output logic [2:0]               rgb_bottom,
    output logic                     pixel_clk
);

    types::brightness_level_t mask_d;
    logic                     load_d;

    // picks the current plane bit of each channel, r g b order
    function automatic logic [2:0] plane_bits(types::pixel_t p, types::brightness_level_t m);
        return {|(p.red & m), |(p.green & m), |(p.blue & m)};
    endfunction

    // control path lines up with the memory read
    always_ff @(posedge clk_in) begin
        if (reset) begin
            load_d    <= 1'b0;
            pixel_clk <= 1'b0;
        end else begin
            load_d    <= load_en;
            pixel_clk <= load_d;
        end
    end

    // data path
    always_ff @(posedge clk_in) begin
        mask_d     <= brightness_mask;
        rgb_top    <= plane_bits(pixel_top, mask_d);
        rgb_bottom <= plane_bits(pixel_bottom, mask_d);
    end

endmodule

/* hdl/led_matrix_top.sv */
//**********************************************************
// column_address runs 2 cycles ahead of rgb and pixel_clk,
// the host must track its own write credits
//**********************************************************

module led_matrix_top #(
    parameter int unsigned BRIGHTNESS_BASE_TIMEOUT = params::BRIGHTNESS_BASE_TIMEOUT,
    parameter int unsigned BRIGHTNESS_STATE_TIMEOUT_OVERLAP =
        params::BRIGHTNESS_STATE_TIMEOUT_OVERLAP,
    parameter int unsigned FB_CREDITS = params::FB_CREDITS
) (
    input  logic                     clk_in,
    input  logic                     reset,
    // host write port
    input  logic                     wr_valid,
    input  types::fb_addr_t          wr_addr,
    input  types::pixel_t            wr_data,
    output logic                     credit_return,
    // panel side
    output types::col_addr_t         column_address,
    output types::row_addr_t         row_address_active,
    output logic                     row_latch,
    output logic                     output_enable,
    output logic [2:0]               rgb_top,
    output logic [2:0]               rgb_bottom,
    output logic                     pixel_clk,
    output types::brightness_level_t brightness_mask
);

    types::row_addr_t row_address;
    logic             load_en;
    types::pixel_t    pixel_top;
    types::pixel_t    pixel_bottom;

    matrix_scan #(
        .BRIGHTNESS_BASE_TIMEOUT         (BRIGHTNESS_BASE_TIMEOUT),
        .BRIGHTNESS_STATE_TIMEOUT_OVERLAP(BRIGHTNESS_STATE_TIMEOUT_OVERLAP)
    ) scan (
        .clk_in            (clk_in),
        .reset             (reset),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .load_en           (load_en),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .brightness_mask   (brightness_mask)
    );

    frame_buffer #(
        .FB_CREDITS(FB_CREDITS)
    ) fb (
        .clk_in        (clk_in),
        .reset         (reset),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .credit_return (credit_return),
        .load_en       (load_en),
        .column_address(column_address),
        .row_address   (row_address),
        .pixel_top     (pixel_top),
        .pixel_bottom  (pixel_bottom)
    );

    pixel_shifter shifter (
        .clk_in         (clk_in),
        .reset          (reset),
        .pixel_top      (pixel_top),
        .pixel_bottom   (pixel_bottom),
        .brightness_mask(brightness_mask),
        .load_en        (load_en),
        .rgb_top        (rgb_top),
        .rgb_bottom     (rgb_bottom),
        .pixel_clk      (pixel_clk)
    );

endmodule

/* sim/led_matrix_asserts.sv */
//************************************************************
// bound into frame_buffer and matrix_scan; each binding ties
// off the inputs its target does not have
//************************************************************

module scan_fifo_asserts #(
    parameter int unsigned DEPTH = params::FB_CREDITS
) (
    input logic        clk_in,
    input logic        reset,
    input logic        push,
    input logic        pop,
    input int unsigned fill,
    input logic        load_en,
    input logic        row_latch
);

    // queue level never above the credit count
    fill_in_range: assert property (@(posedge clk_in) disable iff (reset)
        fill <= DEPTH)
        else $error("write queue fill above its depth");

    // push into a full queue only while the head drains
    no_overflow: assert property (@(posedge clk_in) disable iff (reset)
        !(push && !pop && fill == DEPTH))
        else $error("write pushed into a full queue");

    // latch is a single cycle strobe
    latch_one_cycle: assert property (@(posedge clk_in) disable iff (reset)
        row_latch |=> !row_latch)
        else $error("row_latch held longer than one cycle");

    no_load_on_latch: assert property (@(posedge clk_in) disable iff (reset)
        !(load_en && row_latch))
        else $error("load_en high during row_latch");

endmodule

bind frame_buffer scan_fifo_asserts #(
    .DEPTH(FB_CREDITS)
) fb_checks (
    .clk_in   (clk_in),
    .reset    (reset),
    .push     (wr_valid),
    .pop      (pop),
    .fill     (32'(fifo_count)),
    .load_en  (load_en),
    .row_latch(1'b0)
);

bind matrix_scan scan_fifo_asserts scan_checks (
    .clk_in   (clk_in),
    .reset    (reset),
    .push     (1'b0),
    .pop      (1'b0),
    .fill     (32'd0),
    .load_en  (load_en),
    .row_latch(row_latch)
);

/* sim/led_matrix_tb.sv */
//************************************************************
// random host writes from seed 45; pixels are only compared once
// the queue has drained and a whole frame has scanned out
//************************************************************

module led_matrix_tb;

    localparam int WIDTH = params::PIXEL_WIDTH;
    localparam int HALF_H = params::PIXEL_HALFHEIGHT;
    localparam int LEVELS = params::BRIGHTNESS_LEVELS;
    localparam int BASE = params::BRIGHTNESS_BASE_TIMEOUT;
    localparam int CREDITS = params::FB_CREDITS;
    localparam int FRAME_ADDRS = 2 * HALF_H * WIDTH;
    localparam int ADDR_W = $bits(types::fb_addr_t);
    localparam int PIX_W = $bits(types::pixel_t);
    localparam int REWRITES = 32;
    localparam int FINAL_WRITES = 16;
    localparam int LATCHES_PER_FRAME = HALF_H * LEVELS;
    // upper bound per plane is load, latch delay and its full enable
    localparam int FRAME_CYCLES = HALF_H * (LEVELS * (WIDTH + 6) + BASE * ((1 << LEVELS) - 1));
    localparam int WATCHDOG_CYCLES = 2 * 3 * FRAME_CYCLES;
    // a full queue drains within one load period per entry
    localparam int DRAIN_CYCLES = CREDITS * (WIDTH + 6) + 4;
    localparam types::brightness_level_t MASK_MSB = 1 << (LEVELS - 1);

    logic                     clk_in;
    logic                     reset;
    logic                     wr_valid;
    types::fb_addr_t          wr_addr;
    types::pixel_t            wr_data;
    logic                     credit_return;
    types::col_addr_t         column_address;
    types::row_addr_t         row_address_active;
    logic                     row_latch;
    logic                     output_enable;
    logic [2:0]               rgb_top;
    logic [2:0]               rgb_bottom;
    logic                     pixel_clk;
    types::brightness_level_t brightness_mask;

    // host side model
    types::pixel_t   model_mem [FRAME_ADDRS];
    types::fb_addr_t next_addr;
    types::pixel_t   next_data;
    int              credits;
    int              sent_count;
    int              returned_count;
    int              writes_left;
    int              seq_addr;
    int              latch_mark;
    logic            check_en;
    int              pixel_errors = 0;
    int              scan_errors = 0;
    int              credit_errors = 0;

    // panel side model
    types::brightness_level_t exp_mask;
    types::row_addr_t         exp_row;
    types::brightness_level_t active_mask;
    types::row_addr_t         exp_row_active;
    types::col_addr_t         col_d1;
    types::col_addr_t         col_d2;
    logic [2:0]               exp_top;
    logic [2:0]               exp_bottom;
    int                       pix_count;
    int                       oe_count;
    int                       latch_count;
    int                       post_reset;
    logic                     seen_latch;

    always #2 clk_in = ~clk_in;

    led_matrix_top #(
        .BRIGHTNESS_BASE_TIMEOUT         (BASE),
        .BRIGHTNESS_STATE_TIMEOUT_OVERLAP(params::BRIGHTNESS_STATE_TIMEOUT_OVERLAP),
        .FB_CREDITS                      (CREDITS)
    ) DUT (
        .clk_in            (clk_in),
        .reset             (reset),
        .wr_valid          (wr_valid),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .credit_return     (credit_return),
        .column_address    (column_address),
        .row_address_active(row_address_active),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom),
        .pixel_clk         (pixel_clk),
        .brightness_mask   (brightness_mask)
    );

    // bit position of a one-hot plane mask
    function automatic int plane_index(types::brightness_level_t m);
        int idx;
        idx = 0;
        for (int i = 0; i < LEVELS; i++) begin
            if (m[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // r g b bits of one pixel at one plane
    function automatic logic [2:0] expected_rgb(types::pixel_t p, int plane);
        return {p.red[plane], p.green[plane], p.blue[plane]};
    endfunction

    // host writer, sends only while it holds a credit
    always @(posedge clk_in) begin
        if (reset) begin
            wr_valid       <= 1'b0;
            credits        = CREDITS;
            sent_count     = 0;
            returned_count = 0;
            seq_addr       = 0;
        end else begin
            if (credit_return) begin
                credits        = credits + 1;
                returned_count = returned_count + 1;
            end
            assert (credits <= CREDITS) else begin
                credit_errors++;
                $display("credit returned at %0t while all %0d credits were held", $time, CREDITS);
            end
            if (writes_left > 0 && credits > 0 && ($urandom % 4) != 0) begin
                // whole frame in order first, then random rewrites
                if (seq_addr < FRAME_ADDRS) begin
                    next_addr = ADDR_W'(seq_addr);
                    seq_addr  = seq_addr + 1;
                end else begin
                    next_addr = ADDR_W'($urandom % FRAME_ADDRS);
                end
                next_data = PIX_W'($urandom);
                model_mem[{next_addr.half, next_addr.row, next_addr.col}] = next_data;
                wr_valid    <= 1'b1;
                wr_addr     <= next_addr;
                wr_data     <= next_data;
                credits     = credits - 1;
                sent_count  = sent_count + 1;
                writes_left = writes_left - 1;
            end else begin
                wr_valid <= 1'b0;
            end
        end
    end

    // panel model, sees the values from before each edge
    always @(posedge clk_in) begin
        if (reset) begin
            exp_mask       = MASK_MSB;
            exp_row        = '0;
            active_mask    = '0;
            exp_row_active = '0;
            col_d1         = '0;
            col_d2         = '0;
            pix_count      = 0;
            oe_count       = 0;
            latch_count    = 0;
            post_reset     = 0;
            seen_latch     = 1'b0;
        end else begin
            post_reset = post_reset + 1;
            // quiet window right after reset
            if (post_reset <= 3) begin
                assert (!pixel_clk && !credit_return && !row_latch) else begin
                    scan_errors++;
                    $display("panel or credit strobe active at %0t just after reset", $time);
                end
            end
            if (!seen_latch) begin
                assert (!output_enable) else begin
                    scan_errors++;
                    $display("FAIL t=%0t output_enable expected 0 got 1", $time);
                end
            end
            assert (brightness_mask == exp_mask) else begin
                scan_errors++;
                $display("FAIL t=%0t brightness_mask expected %b got %b",
                         $time, exp_mask, brightness_mask);
            end
            assert (row_address_active == exp_row_active) else begin
                scan_errors++;
                $display("FAIL t=%0t row_address_active expected %0d got %0d",
                         $time, exp_row_active, row_address_active);
            end
            if (pixel_clk) begin
                // columns leave in descending order
                assert (int'(col_d2) == WIDTH - 1 - pix_count) else begin
                    scan_errors++;
                    $display("FAIL t=%0t column_address expected %0d got %0d",
                             $time, WIDTH - 1 - pix_count, col_d2);
                end
                if (check_en) begin
                    exp_top    = expected_rgb(model_mem[{1'b0, exp_row, col_d2}],
                                              plane_index(exp_mask));
                    exp_bottom = expected_rgb(model_mem[{1'b1, exp_row, col_d2}],
                                              plane_index(exp_mask));
                    assert (rgb_top == exp_top) else begin
                        pixel_errors++;
                        $display("FAIL t=%0t rgb_top expected %b got %b", $time, exp_top, rgb_top);
                    end
                    assert (rgb_bottom == exp_bottom) else begin
                        pixel_errors++;
                        $display("FAIL t=%0t rgb_bottom expected %b got %b",
                                 $time, exp_bottom, rgb_bottom);
                    end
                end
                pix_count = pix_count + 1;
            end
            if (row_latch) begin
                assert (pix_count == WIDTH) else begin
                    scan_errors++;
                    $display("FAIL t=%0t pixel_clk count expected %0d got %0d",
                             $time, WIDTH, pix_count);
                end
                // loaded plane becomes the shown plane
                active_mask    = exp_mask;
                exp_row_active = exp_row;
                if (exp_mask[0]) begin
                    exp_mask = MASK_MSB;
                    exp_row  = (int'(exp_row) == HALF_H - 1) ? '0 : exp_row + 1'b1;
                end else begin
                    exp_mask = exp_mask >> 1;
                end
                pix_count   = 0;
                oe_count    = 0;
                latch_count = latch_count + 1;
                seen_latch  = 1'b1;
            end else if (output_enable) begin
                oe_count = oe_count + 1;
            end else if (oe_count != 0) begin
                // pulse just ended, length weighted by the shown plane
                assert (oe_count == (BASE << plane_index(active_mask))) else begin
                    scan_errors++;
                    $display("FAIL t=%0t output_enable width expected %0d got %0d",
                             $time, BASE << plane_index(active_mask), oe_count);
                end
                oe_count = 0;
            end
            col_d2 = col_d1;
            col_d1 = column_address;
        end
    end

    // run sequence
    initial begin
        void'($urandom(45));
        clk_in      = 1'b0;
        reset       = 1'b1;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        writes_left = 0;
        check_en    = 1'b0;
        repeat (10) @(posedge clk_in);
        reset <= 1'b0;
        @(negedge clk_in);
        writes_left = FRAME_ADDRS + REWRITES;
        wait (writes_left == 0 && credits == CREDITS);
        // one settling frame, then two checked frames
        @(negedge clk_in);
        latch_mark = latch_count;
        wait (latch_count >= latch_mark + LATCHES_PER_FRAME);
        @(negedge clk_in);
        check_en = 1'b1;
        wait (latch_count >= latch_mark + 3 * LATCHES_PER_FRAME);
        @(negedge clk_in);
        check_en    = 1'b0;
        writes_left = FINAL_WRITES;
        wait (writes_left == 0);
        // queue must be empty and every credit back after the drain window
        repeat (DRAIN_CYCLES) @(posedge clk_in);
        assert (returned_count == sent_count) else begin
            credit_errors++;
            $display("FAIL t=%0t credit_return count expected %0d got %0d",
                     $time, sent_count, returned_count);
        end
        $display("errors: pixel %0d, scan %0d, credit %0d",
                 pixel_errors, scan_errors, credit_errors);
        if (pixel_errors + scan_errors + credit_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* project.f */
hdl/params_pkg.sv
hdl/types_pkg.sv
hdl/timeout.sv
hdl/brightness_timeout.sv
hdl/matrix_scan.sv
hdl/frame_buffer.sv
hdl/pixel_shifter.sv
hdl/led_matrix_top.sv
sim/led_matrix_asserts.sv
sim/led_matrix_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module led_matrix_tb -f project.f &&
./obj_dir/Vled_matrix_tb | awk '{ print } /ALL TESTS PASSED/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
